// ==== rob_pkg.sv ====
`default_nettype none

// Shared sizes, encodings and bundles for the reorder buffer and its testbench
package rob_pkg;

    // Buffer geometry
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_WIDTH = 3;
    // The occupancy counter must be able to hold ROB_DEPTH itself
    localparam int ROB_COUNT_WIDTH = 4;

    // Datapath widths
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int RDST_WIDTH = 5;

    // Number of common data buses feeding completions
    localparam int CDB_DEPTH = 2;

    // One-hot op kind and the position of each kind in it
    localparam int OP_IS_WIDTH = 4;
    localparam int OP_IS_ALU_IDX = 0;
    localparam int OP_IS_LD_IDX = 1;
    localparam int OP_IS_ST_IDX = 2;
    localparam int OP_IS_JL_IDX = 3;

    // Life cycle of one entry
    // Loads and stores pass through LSU_PENDING, every other op skips it
    typedef enum logic [1:0] {
        INVALID     = 2'b00,
        PENDING     = 2'b01,
        LSU_PENDING = 2'b10,
        RETIRABLE   = 2'b11
    } rob_state_e;

    // Fields written into an entry when an op is dispatched
    typedef struct packed {
        logic [OP_IS_WIDTH-1:0] op_is;
        logic [ADDR_WIDTH-1:0]  pc;
        logic [RDST_WIDTH-1:0]  rdst;
        logic [DATA_WIDTH-1:0]  data;
    } rob_dispatch_t;

    // One completion bus, data carries a jump target for jump ops
    typedef struct packed {
        logic                     en;
        logic                     redirect;
        logic [ROB_TAG_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0]    data;
    } cdb_t;

    // Everything an entry exposes to the retire logic
    typedef struct packed {
        rob_state_e             state;
        logic                   redirect;
        logic [OP_IS_WIDTH-1:0] op_is;
        logic [ADDR_WIDTH-1:0]  pc;
        logic [RDST_WIDTH-1:0]  rdst;
        logic [DATA_WIDTH-1:0]  data;
    } rob_entry_t;

    // What leaves the buffer when the head retires
    typedef struct packed {
        logic                   redirect;
        logic [OP_IS_WIDTH-1:0] op_is;
        logic [ADDR_WIDTH-1:0]  pc;
        logic [RDST_WIDTH-1:0]  rdst;
        logic [DATA_WIDTH-1:0]  data;
    } rob_retire_t;

endpackage

`default_nettype wire

// ==== rob_entry.sv ====
`default_nettype none

// A single reorder-buffer slot
// It walks INVALID -> PENDING -> (LSU_PENDING) -> RETIRABLE -> INVALID
module rob_entry (
    input  wire logic                               clk,
    input  wire logic                               i_reset,
    input  wire logic [rob_pkg::ROB_TAG_WIDTH-1:0]  i_tag,
    input  wire logic                               i_flush,
    input  wire logic                               i_dispatch_en,
    input  wire rob_pkg::rob_dispatch_t             i_dispatch,
    input  wire rob_pkg::cdb_t                      i_cdb [rob_pkg::CDB_DEPTH],
    input  wire logic                               i_retire_en,
    input  wire logic                               i_lq_ack,
    input  wire logic                               i_sq_ack,
    input  wire logic                               i_misspeculated,
    output rob_pkg::rob_entry_t                     o_entry
);

    rob_pkg::rob_state_e state_r;
    rob_pkg::rob_state_e state_next;

    logic                               redirect_r;
    logic [rob_pkg::OP_IS_WIDTH-1:0]    op_is_r;
    logic [rob_pkg::ADDR_WIDTH-1:0]     pc_r;
    logic [rob_pkg::RDST_WIDTH-1:0]     rdst_r;
    logic [rob_pkg::DATA_WIDTH-1:0]     data_r;

    logic                               redirect_next;
    logic [rob_pkg::ADDR_WIDTH-1:0]     pc_next;
    logic [rob_pkg::DATA_WIDTH-1:0]     data_next;

    logic [rob_pkg::CDB_DEPTH-1:0]      cdb_hit;
    logic                               cdb_any;
    logic                               is_pending;
    logic                               is_lsu_pending;
    logic                               is_jump;
    logic                               is_lsu_op;
    logic                               lq_ack_hit;
    logic                               sq_ack_hit;

    assign is_pending = (state_r == rob_pkg::PENDING);
    assign is_lsu_pending = (state_r == rob_pkg::LSU_PENDING);
    assign is_jump = op_is_r[rob_pkg::OP_IS_JL_IDX];
    assign is_lsu_op = op_is_r[rob_pkg::OP_IS_LD_IDX] | op_is_r[rob_pkg::OP_IS_ST_IDX];

    // An ack only counts when this slot waits for it and the op kind agrees
    assign lq_ack_hit = is_lsu_pending & op_is_r[rob_pkg::OP_IS_LD_IDX] & i_lq_ack;
    assign sq_ack_hit = is_lsu_pending & op_is_r[rob_pkg::OP_IS_ST_IDX] & i_sq_ack;

    // Completions are only accepted while the op is still outstanding
    always_comb begin
        for (int i = 0; i < rob_pkg::CDB_DEPTH; i++) begin
            cdb_hit[i] = is_pending & i_cdb[i].en & (i_cdb[i].tag == i_tag);
        end
    end

    assign cdb_any = |cdb_hit;

    // Payload update, later buses win when several match in the same cycle
    always_comb begin
        redirect_next = redirect_r;
        pc_next = pc_r;
        data_next = data_r;

        for (int i = 0; i < rob_pkg::CDB_DEPTH; i++) begin
            if (cdb_hit[i]) begin
                redirect_next = i_cdb[i].redirect;
                // A jump returns its target address, which replaces the PC
                if (is_jump) begin
                    pc_next = i_cdb[i].data;
                end else begin
                    data_next = i_cdb[i].data;
                end
            end
        end

        // The load queue reports here whether the load read stale data
        if (lq_ack_hit) begin
            redirect_next = i_misspeculated;
        end

        // A new op overwrites the slot and starts with no redirect pending
        if (i_dispatch_en) begin
            redirect_next = 1'b0;
            pc_next = i_dispatch.pc;
            data_next = i_dispatch.data;
        end
    end

    always_ff @(posedge clk) begin
        redirect_r <= redirect_next;
        pc_r <= pc_next;
        data_r <= data_next;
        // Op kind and destination are fixed for the life of the op
        if (i_dispatch_en) begin
            op_is_r <= i_dispatch.op_is;
            rdst_r <= i_dispatch.rdst;
        end
    end

    // Next state of the slot
    always_comb begin
        state_next = state_r;
        case (state_r)
            rob_pkg::INVALID: begin
                if (i_dispatch_en) state_next = rob_pkg::PENDING;
            end
            rob_pkg::PENDING: begin
                if (cdb_any) begin
                    state_next = is_lsu_op ? rob_pkg::LSU_PENDING : rob_pkg::RETIRABLE;
                end
            end
            rob_pkg::LSU_PENDING: begin
                if (lq_ack_hit | sq_ack_hit) state_next = rob_pkg::RETIRABLE;
            end
            rob_pkg::RETIRABLE: begin
                if (i_retire_en) state_next = rob_pkg::INVALID;
            end
            default: state_next = rob_pkg::INVALID;
        endcase

        // A redirect at retirement empties every slot
        if (i_flush) begin
            state_next = rob_pkg::INVALID;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= rob_pkg::INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    assign o_entry = '{
        state:    state_r,
        redirect: redirect_r,
        op_is:    op_is_r,
        pc:       pc_r,
        rdst:     rdst_r,
        data:     data_r
    };

endmodule

`default_nettype wire

// ==== rob_ptr_ctrl.sv ====
`default_nettype none

// Circular-buffer bookkeeping for the reorder buffer
// Dispatch goes in at the tail and retirement leaves from the head
module rob_ptr_ctrl (
    input  wire logic                           clk,
    input  wire logic                           i_reset,
    input  wire logic                           i_dispatch_en,
    input  wire logic                           i_retire_en,
    input  wire logic                           i_flush,
    output logic [rob_pkg::ROB_DEPTH-1:0]       o_dispatch_sel,
    output logic [rob_pkg::ROB_TAG_WIDTH-1:0]   o_tail,
    output logic [rob_pkg::ROB_TAG_WIDTH-1:0]   o_head,
    output logic                                o_full
);

    localparam logic [rob_pkg::ROB_TAG_WIDTH-1:0] LAST_TAG =
        rob_pkg::ROB_TAG_WIDTH'(rob_pkg::ROB_DEPTH - 1);

    logic [rob_pkg::ROB_TAG_WIDTH-1:0]      tail_r;
    logic [rob_pkg::ROB_TAG_WIDTH-1:0]      head_r;
    logic [rob_pkg::ROB_COUNT_WIDTH-1:0]    count_r;
    logic                                   dispatch_fire;

    assign o_full = (count_r == rob_pkg::ROB_COUNT_WIDTH'(rob_pkg::ROB_DEPTH));

    // A dispatch is dropped when the buffer is full or is being flushed
    assign dispatch_fire = i_dispatch_en & ~o_full & ~i_flush;

    // Only the slot under the tail sees the dispatch
    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            o_dispatch_sel[i] = dispatch_fire & (tail_r == rob_pkg::ROB_TAG_WIDTH'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            tail_r <= '0;
            head_r <= '0;
            count_r <= '0;
        end else begin
            if (dispatch_fire) begin
                tail_r <= (tail_r == LAST_TAG) ? '0 : tail_r + 1'b1;
            end
            if (i_retire_en) begin
                head_r <= (head_r == LAST_TAG) ? '0 : head_r + 1'b1;
            end
            // Occupancy holds when one op enters and one leaves together
            case ({dispatch_fire, i_retire_en})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    assign o_tail = tail_r;
    assign o_head = head_r;

endmodule

`default_nettype wire

// ==== rob_retire_sel.sv ====
`default_nettype none

// Looks at the head slot only and decides retirement, flush and LSU routing
module rob_retire_sel (
    input  wire rob_pkg::rob_entry_t                i_entries [rob_pkg::ROB_DEPTH],
    input  wire logic [rob_pkg::ROB_TAG_WIDTH-1:0]  i_head,
    input  wire logic                               i_lsu_lq_ack,
    input  wire logic                               i_lsu_sq_ack,
    input  wire logic                               i_lsu_misspeculated,
    output logic                                    o_retire_en,
    output logic [rob_pkg::ROB_DEPTH-1:0]           o_retire_sel,
    output logic [rob_pkg::ROB_DEPTH-1:0]           o_lq_ack,
    output logic [rob_pkg::ROB_DEPTH-1:0]           o_sq_ack,
    output logic [rob_pkg::ROB_DEPTH-1:0]           o_misspeculated,
    output logic                                    o_lsu_pending,
    output logic                                    o_flush,
    output rob_pkg::rob_retire_t                    o_retire
);

    rob_pkg::rob_entry_t head_entry;
    logic [rob_pkg::ROB_DEPTH-1:0] head_onehot;

    assign head_entry = i_entries[i_head];

    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            head_onehot[i] = (i_head == rob_pkg::ROB_TAG_WIDTH'(i));
        end
    end

    // The head leaves as soon as it is done, nothing downstream can stall it
    assign o_retire_en = (head_entry.state == rob_pkg::RETIRABLE);
    assign o_retire_sel = head_onehot & {rob_pkg::ROB_DEPTH{o_retire_en}};

    // A redirecting op empties the buffer in the same cycle it retires
    assign o_flush = o_retire_en & head_entry.redirect;

    // The LSU retires in order, so its acks always belong to the head
    assign o_lq_ack = head_onehot & {rob_pkg::ROB_DEPTH{i_lsu_lq_ack}};
    assign o_sq_ack = head_onehot & {rob_pkg::ROB_DEPTH{i_lsu_sq_ack}};
    assign o_misspeculated = head_onehot & {rob_pkg::ROB_DEPTH{i_lsu_misspeculated}};

    // Tells the LSU that the head is waiting on its ack
    assign o_lsu_pending = (head_entry.state == rob_pkg::LSU_PENDING);

    assign o_retire = '{
        redirect: head_entry.redirect,
        op_is:    head_entry.op_is,
        pc:       head_entry.pc,
        rdst:     head_entry.rdst,
        data:     head_entry.data
    };

endmodule

`default_nettype wire

// ==== rob_top.sv ====
`default_nettype none

// Reorder buffer top level
// Slots hold ops in program order from dispatch until in-order retirement
module rob_top (
    input  wire logic                               clk,
    input  wire logic                               i_reset,
    input  wire logic                               i_dispatch_en,
    input  wire rob_pkg::rob_dispatch_t             i_dispatch,
    input  wire rob_pkg::cdb_t                      i_cdb [rob_pkg::CDB_DEPTH],
    input  wire logic                               i_lsu_lq_ack,
    input  wire logic                               i_lsu_sq_ack,
    input  wire logic                               i_lsu_misspeculated,
    output logic [rob_pkg::ROB_TAG_WIDTH-1:0]       o_dispatch_tag,
    output logic                                    o_full,
    output logic                                    o_lsu_pending,
    output logic                                    o_retire_en,
    output rob_pkg::rob_retire_t                    o_retire,
    output logic                                    o_flush
);

    // Per-slot control from the pointer and retire logic
    logic [rob_pkg::ROB_DEPTH-1:0]      dispatch_sel;
    logic [rob_pkg::ROB_DEPTH-1:0]      retire_sel;
    logic [rob_pkg::ROB_DEPTH-1:0]      lq_ack;
    logic [rob_pkg::ROB_DEPTH-1:0]      sq_ack;
    logic [rob_pkg::ROB_DEPTH-1:0]      misspeculated;
    logic [rob_pkg::ROB_TAG_WIDTH-1:0]  head_tag;

    // Contents of every slot as seen by the retire logic
    rob_pkg::rob_entry_t entries [rob_pkg::ROB_DEPTH];

    // The tail is the tag handed back to dispatch
    rob_ptr_ctrl u_ptr_ctrl (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_dispatch_en  (i_dispatch_en),
        .i_retire_en    (o_retire_en),
        .i_flush        (o_flush),
        .o_dispatch_sel (dispatch_sel),
        .o_tail         (o_dispatch_tag),
        .o_head         (head_tag),
        .o_full         (o_full)
    );

    for (genvar g = 0; g < rob_pkg::ROB_DEPTH; g++) begin : g_entry
        // Each slot answers to its own position in the buffer
        localparam logic [rob_pkg::ROB_TAG_WIDTH-1:0] ENTRY_TAG = rob_pkg::ROB_TAG_WIDTH'(g);

        rob_entry u_entry (
            .clk             (clk),
            .i_reset         (i_reset),
            .i_tag           (ENTRY_TAG),
            .i_flush         (o_flush),
            .i_dispatch_en   (dispatch_sel[g]),
            .i_dispatch      (i_dispatch),
            .i_cdb           (i_cdb),
            .i_retire_en     (retire_sel[g]),
            .i_lq_ack        (lq_ack[g]),
            .i_sq_ack        (sq_ack[g]),
            .i_misspeculated (misspeculated[g]),
            .o_entry         (entries[g])
        );
    end

    rob_retire_sel u_retire_sel (
        .i_entries           (entries),
        .i_head              (head_tag),
        .i_lsu_lq_ack        (i_lsu_lq_ack),
        .i_lsu_sq_ack        (i_lsu_sq_ack),
        .i_lsu_misspeculated (i_lsu_misspeculated),
        .o_retire_en         (o_retire_en),
        .o_retire_sel        (retire_sel),
        .o_lq_ack            (lq_ack),
        .o_sq_ack            (sq_ack),
        .o_misspeculated     (misspeculated),
        .o_lsu_pending       (o_lsu_pending),
        .o_flush             (o_flush),
        .o_retire            (o_retire)
    );

endmodule

`default_nettype wire

// ==== tb_rob.sv ====
`default_nettype none

// Testbench for the reorder buffer
// A reference model, updated at every falling edge from the inputs it sees,
// predicts every output of the DUT for the cycle that follows
module tb_rob;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD_NS = 10;
    localparam int RAND_CYCLES = 300;
    localparam int TAIL_CYCLES = 30;
    // Budget for the directed tests and the drains between them
    localparam int DIRECTED_CYCLES = 150;
    localparam int STIM_CYCLES = RAND_CYCLES + TAIL_CYCLES + DIRECTED_CYCLES;
    localparam int WATCHDOG_NS = 20 * STIM_CYCLES * CLK_PERIOD_NS;

    logic                                   clk = 1'b0;
    logic                                   i_reset;
    logic                                   i_dispatch_en;
    rob_pkg::rob_dispatch_t                 i_dispatch;
    rob_pkg::cdb_t                          i_cdb [rob_pkg::CDB_DEPTH];
    logic                                   i_lsu_lq_ack;
    logic                                   i_lsu_sq_ack;
    logic                                   i_lsu_misspeculated;
    logic [rob_pkg::ROB_TAG_WIDTH-1:0]      o_dispatch_tag;
    logic                                   o_full;
    logic                                   o_lsu_pending;
    logic                                   o_retire_en;
    rob_pkg::rob_retire_t                   o_retire;
    logic                                   o_flush;

    // Reference model of the buffer, one state and one payload per tag
    rob_pkg::rob_state_e                    model_st [rob_pkg::ROB_DEPTH];
    rob_pkg::rob_retire_t                   model_ent [rob_pkg::ROB_DEPTH];
    int unsigned                            order_q [$];
    logic [rob_pkg::ROB_TAG_WIDTH-1:0]      model_tail;
    int                                     retire_count = 0;
    int                                     flush_count = 0;
    logic [31:0]                            rng;

    rob_top i_dut (
        .clk                 (clk),
        .i_reset             (i_reset),
        .i_dispatch_en       (i_dispatch_en),
        .i_dispatch          (i_dispatch),
        .i_cdb               (i_cdb),
        .i_lsu_lq_ack        (i_lsu_lq_ack),
        .i_lsu_sq_ack        (i_lsu_sq_ack),
        .i_lsu_misspeculated (i_lsu_misspeculated),
        .o_dispatch_tag      (o_dispatch_tag),
        .o_full              (o_full),
        .o_lsu_pending       (o_lsu_pending),
        .o_retire_en         (o_retire_en),
        .o_retire            (o_retire),
        .o_flush             (o_flush)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    task automatic report_value(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h",
                 $time, name, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "stopped on an error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] word;
        word = rand_word();
        return word[0];
    endfunction

    function automatic logic [rob_pkg::OP_IS_WIDTH-1:0] one_hot_op(input int idx);
        logic [rob_pkg::OP_IS_WIDTH-1:0] op;
        op = '0;
        op[idx] = 1'b1;
        return op;
    endfunction

    // True while the oldest op has completed and waits for the LSU
    function automatic logic lsu_head();
        return (order_q.size() > 0) && (model_st[order_q[0]] == rob_pkg::LSU_PENDING);
    endfunction

    task automatic reset_model();
        for (int t = 0; t < rob_pkg::ROB_DEPTH; t++) begin
            model_st[t] = rob_pkg::INVALID;
        end
        order_q.delete();
        model_tail = '0;
    endtask

    task automatic check_outputs();
        int unsigned head;
        logic head_ready;
        logic head_lsu;
        head = (order_q.size() > 0) ? order_q[0] : 0;
        head_ready = (order_q.size() > 0) && (model_st[head] == rob_pkg::RETIRABLE);
        head_lsu = lsu_head();
        assert (o_full == (order_q.size() == rob_pkg::ROB_DEPTH))
            else report_value("o_full", order_q.size() == rob_pkg::ROB_DEPTH, o_full);
        assert (o_dispatch_tag == model_tail)
            else report_value("o_dispatch_tag", model_tail, o_dispatch_tag);
        assert (o_retire_en == head_ready)
            else report_value("o_retire_en", head_ready, o_retire_en);
        assert (o_lsu_pending == head_lsu)
            else report_value("o_lsu_pending", head_lsu, o_lsu_pending);
        if (head_ready) begin
            assert (o_retire == model_ent[head])
                else report_value("o_retire", model_ent[head], o_retire);
            assert (o_flush == model_ent[head].redirect)
                else report_value("o_flush", model_ent[head].redirect, o_flush);
        end else begin
            assert (!o_flush) else report_value("o_flush", 1'b0, o_flush);
        end
    endtask

    // Applies what the inputs of this cycle do at the next rising edge
    task automatic update_model();
        rob_pkg::rob_state_e st_old [rob_pkg::ROB_DEPTH];
        int unsigned head;
        int unsigned t;
        logic retire;
        logic flush;
        logic accept;
        st_old = model_st;
        head = (order_q.size() > 0) ? order_q[0] : 0;
        retire = (order_q.size() > 0) && (st_old[head] == rob_pkg::RETIRABLE);
        flush = retire && model_ent[head].redirect;
        accept = i_dispatch_en && (order_q.size() < rob_pkg::ROB_DEPTH) && !flush;
        for (int p = 0; p < rob_pkg::CDB_DEPTH; p++) begin
            t = i_cdb[p].tag;
            if (i_cdb[p].en && (st_old[t] == rob_pkg::PENDING)) begin
                model_ent[t].redirect = i_cdb[p].redirect;
                // A jump reports its target, every other op reports a value
                if (model_ent[t].op_is[rob_pkg::OP_IS_JL_IDX]) begin
                    model_ent[t].pc = i_cdb[p].data;
                end else begin
                    model_ent[t].data = i_cdb[p].data;
                end
                model_st[t] = (model_ent[t].op_is[rob_pkg::OP_IS_LD_IDX] ||
                               model_ent[t].op_is[rob_pkg::OP_IS_ST_IDX]) ?
                              rob_pkg::LSU_PENDING : rob_pkg::RETIRABLE;
            end
        end
        if ((order_q.size() > 0) && (st_old[head] == rob_pkg::LSU_PENDING)) begin
            if (i_lsu_lq_ack && model_ent[head].op_is[rob_pkg::OP_IS_LD_IDX]) begin
                model_st[head] = rob_pkg::RETIRABLE;
                model_ent[head].redirect = i_lsu_misspeculated;
            end
            if (i_lsu_sq_ack && model_ent[head].op_is[rob_pkg::OP_IS_ST_IDX]) begin
                model_st[head] = rob_pkg::RETIRABLE;
            end
        end
        if (retire) begin
            model_st[head] = rob_pkg::INVALID;
            void'(order_q.pop_front());
            retire_count++;
        end
        if (accept) begin
            model_ent[model_tail] = '{redirect: 1'b0, op_is: i_dispatch.op_is,
                                      pc: i_dispatch.pc, rdst: i_dispatch.rdst,
                                      data: i_dispatch.data};
            model_st[model_tail] = rob_pkg::PENDING;
            order_q.push_back(model_tail);
            model_tail = model_tail + 1'b1;
        end
        if (flush) begin
            reset_model();
            flush_count++;
        end
    endtask

    // Outputs depend on registers only, so mid-cycle sampling is safe
    always @(negedge clk) begin
        if (i_reset) begin
            reset_model();
        end else begin
            check_outputs();
            update_model();
        end
    end

    // A flush only ever comes with a retirement
    assert property (@(posedge clk) disable iff (i_reset) o_flush |-> o_retire_en)
        else report_value("o_retire_en", 1'b1, o_retire_en);
    // One cycle after a flush the buffer is empty again
    assert property (@(posedge clk) disable iff (i_reset) o_flush |=> (o_dispatch_tag == '0))
        else report_value("o_dispatch_tag", 0, o_dispatch_tag);
    assert property (@(posedge clk) disable iff (i_reset) o_flush |=> !o_full)
        else report_value("o_full", 1'b0, o_full);

    task automatic clear_inputs();
        i_dispatch_en = 1'b0;
        i_dispatch = '0;
        for (int p = 0; p < rob_pkg::CDB_DEPTH; p++) begin
            i_cdb[p] = '0;
        end
        i_lsu_lq_ack = 1'b0;
        i_lsu_sq_ack = 1'b0;
        i_lsu_misspeculated = 1'b0;
    endtask

    // Inputs change 1 ns after the rising edge and last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    task automatic put_dispatch(input logic [rob_pkg::OP_IS_WIDTH-1:0] op);
        i_dispatch_en = 1'b1;
        i_dispatch = '{op_is: op, pc: rand_word(),
                       rdst: rob_pkg::RDST_WIDTH'(rand_word()), data: rand_word()};
    endtask

    task automatic put_cdb(input int port, input int unsigned tag, input logic redirect);
        i_cdb[port] = '{en: 1'b1, redirect: redirect,
                        tag: rob_pkg::ROB_TAG_WIDTH'(tag), data: rand_word()};
    endtask

    // Completes up to one outstanding op per bus, chosen at random
    task automatic complete_pending();
        int unsigned cand [$];
        int unsigned idx;
        for (int t = 0; t < rob_pkg::ROB_DEPTH; t++) begin
            if (model_st[t] == rob_pkg::PENDING) begin
                cand.push_back(t);
            end
        end
        for (int p = 0; p < rob_pkg::CDB_DEPTH; p++) begin
            if ((cand.size() > 0) && rand_bit()) begin
                idx = rand_word() % cand.size();
                put_cdb(p, cand[idx], 1'b0);
                cand.delete(idx);
            end
        end
    endtask

    task automatic ack_lsu_head();
        if (lsu_head()) begin
            if (model_ent[order_q[0]].op_is[rob_pkg::OP_IS_LD_IDX]) begin
                i_lsu_lq_ack = 1'b1;
            end else begin
                i_lsu_sq_ack = 1'b1;
            end
        end
    endtask

    task automatic drain();
        while (order_q.size() > 0) begin
            next_cycle();
            complete_pending();
            ack_lsu_head();
        end
    endtask

    task automatic wait_lsu_head();
        next_cycle();
        while (!lsu_head()) begin
            next_cycle();
        end
        assert (o_lsu_pending) else report_value("o_lsu_pending", 1'b1, o_lsu_pending);
    endtask

    // ALU and jump ops, completed on both buses in random order
    task automatic run_random_ops(input int cycles);
        repeat (cycles) begin
            next_cycle();
            complete_pending();
            if (rand_bit()) begin
                put_dispatch(one_hot_op(rand_bit() ? rob_pkg::OP_IS_JL_IDX :
                                                     rob_pkg::OP_IS_ALU_IDX));
            end
        end
    endtask

    task automatic fill_buffer();
        logic [rob_pkg::ROB_TAG_WIDTH-1:0] tag_before;
        repeat (rob_pkg::ROB_DEPTH) begin
            next_cycle();
            put_dispatch(one_hot_op(rob_pkg::OP_IS_ALU_IDX));
        end
        next_cycle();
        assert (o_full) else report_value("o_full", 1'b1, o_full);
        // No room for this one, it must leave no trace
        tag_before = o_dispatch_tag;
        put_dispatch(one_hot_op(rob_pkg::OP_IS_ALU_IDX));
        next_cycle();
        assert (o_dispatch_tag == tag_before)
            else report_value("o_dispatch_tag", tag_before, o_dispatch_tag);
        put_cdb(0, order_q[0], 1'b0);
    endtask

    task automatic run_lsu_handshake();
        int kinds [4] = '{rob_pkg::OP_IS_LD_IDX, rob_pkg::OP_IS_ST_IDX,
                          rob_pkg::OP_IS_LD_IDX, rob_pkg::OP_IS_ALU_IDX};
        int flushes;
        foreach (kinds[i]) begin
            next_cycle();
            put_dispatch(one_hot_op(kinds[i]));
        end
        next_cycle();
        put_cdb(0, order_q[1], 1'b0);
        put_cdb(1, order_q[2], 1'b0);
        next_cycle();
        put_cdb(0, order_q[0], 1'b0);
        put_cdb(1, order_q[3], 1'b0);
        // First load at the head, a store ack must not release it
        wait_lsu_head();
        i_lsu_sq_ack = 1'b1;
        next_cycle();
        i_lsu_lq_ack = 1'b1;
        // Store at the head ignores a load ack
        wait_lsu_head();
        i_lsu_lq_ack = 1'b1;
        i_lsu_misspeculated = 1'b1;
        next_cycle();
        i_lsu_sq_ack = 1'b1;
        // Second load read stale data and has to redirect
        wait_lsu_head();
        flushes = flush_count;
        i_lsu_lq_ack = 1'b1;
        i_lsu_misspeculated = 1'b1;
        while (flush_count == flushes) begin
            next_cycle();
        end
    endtask

    task automatic run_flush();
        int kinds [4] = '{rob_pkg::OP_IS_ALU_IDX, rob_pkg::OP_IS_JL_IDX,
                          rob_pkg::OP_IS_ALU_IDX, rob_pkg::OP_IS_ALU_IDX};
        int flushes;
        foreach (kinds[i]) begin
            next_cycle();
            put_dispatch(one_hot_op(kinds[i]));
        end
        next_cycle();
        put_cdb(0, order_q[3], 1'b0);
        put_cdb(1, order_q[2], 1'b0);
        next_cycle();
        put_cdb(0, order_q[1], 1'b1);
        next_cycle();
        put_cdb(1, order_q[0], 1'b0);
        // Keep dispatching so that one dispatch lands in the flush cycle
        flushes = flush_count;
        while (flush_count == flushes) begin
            next_cycle();
            put_dispatch(one_hot_op(rob_pkg::OP_IS_ALU_IDX));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_problem("timeout, the run did not finish in the expected time");
    end

    initial begin
        rng = 32'h3758_dc00;
        i_reset = 1'b1;
        clear_inputs();
        repeat (5) @(posedge clk);
        #1;
        i_reset = 1'b0;
        assert (!o_retire_en) else report_value("o_retire_en", 1'b0, o_retire_en);
        assert (!o_flush) else report_value("o_flush", 1'b0, o_flush);
        assert (!o_lsu_pending) else report_value("o_lsu_pending", 1'b0, o_lsu_pending);
        assert (!o_full) else report_value("o_full", 1'b0, o_full);
        assert (o_dispatch_tag == '0) else report_value("o_dispatch_tag", 0, o_dispatch_tag);
        run_random_ops(RAND_CYCLES);
        drain();
        fill_buffer();
        drain();
        run_lsu_handshake();
        drain();
        run_flush();
        run_random_ops(TAIL_CYCLES);
        drain();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rob_pkg.sv
rob_entry.sv
rob_ptr_ctrl.sv
rob_retire_sel.sv
rob_top.sv
tb_rob.sv

// ==== Bender.yml ====
package:
  name: rob

sources:
  - rob_pkg.sv
  - rob_entry.sv
  - rob_ptr_ctrl.sv
  - rob_retire_sel.sv
  - rob_top.sv
  - target: test
    files:
      - tb_rob.sv
